// File: bench/cheat_model.svh
`ifndef CHEAT_MODEL_SVH
`define CHEAT_MODEL_SVH

// lowest enabled slot holding this address, -1 when none does
function automatic int patch_slot(input logic [23:0] addr);
  int hit_slot;
  hit_slot = -1;
  for (int i = 0; i < `CHEAT_SLOTS; i++) begin
    if (hit_slot < 0 && m_mask[3'(i)] && m_addr[3'(i)] == addr) begin
      hit_slot = i;
    end
  end
  return hit_slot;
endfunction

// byte seen at an address with no patch and no region select
function automatic cheat_pkg::snes_byte_t vector_byte(input logic [23:0] addr);
  cheat_pkg::snes_byte_t value;
  value = `FILL_BYTE;
  if (addr == `NMI_VEC_LO) begin
    value = `HOOK_LO_BYTE;
  end else if (addr == `RST_VEC_LO) begin
    value = `RST_LO_BYTE;
  end
  return value;
endfunction

// pad combos in command order, MENU first
function automatic logic [15:0] combo_value(input int k);
  case (k)
    0:       return 16'h3030;
    1:       return 16'h2070;
    2:       return 16'h10B0;
    3:       return 16'h9030;
    4:       return 16'h5030;
    default: return 16'h1070;
  endcase
endfunction

function automatic cheat_pkg::pad_cmd_e pad_cmd_of(input logic [15:0] pad);
  cheat_pkg::pad_cmd_e cmd;
  cmd = cheat_pkg::PAD_NONE;
  for (int k = 0; k < 6; k++) begin
    if (pad == combo_value(k)) begin
      cmd = cheat_pkg::pad_cmd_e'(8'h80 + 8'(k));
    end
  end
  return cmd;
endfunction

function automatic cheat_pkg::snes_byte_t branch1_of(input logic buttons, input logic ajr,
    input logic latch, input logic wram, input cheat_pkg::pad_cmd_e cmd);
  cheat_pkg::snes_byte_t wram_rule;
  wram_rule = wram ? 8'h3A : 8'h43;
  if (buttons && ajr && cmd != cheat_pkg::PAD_NONE) begin
    return 8'h30;
  end
  if (!buttons || ajr || latch) begin
    return wram_rule;
  end
  return 8'h00;
endfunction

function automatic cheat_pkg::snes_byte_t branch2_of(input cheat_pkg::pad_cmd_e cmd,
    input logic wram);
  if (cmd == cheat_pkg::PAD_STOP) begin
    return 8'h14;
  end
  return wram ? 8'h00 : 8'h09;
endfunction

`endif

// File: bench/cheat_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cheat_consts.svh"

module cheat_tb;

  // strobe codes {rd, wr, cycle_start}
  localparam logic [2:0] NONE = 3'b000;
  localparam logic [2:0] RD   = 3'b100;
  localparam logic [2:0] WR   = 3'b010;
  localparam logic [2:0] CS   = 3'b001;
  // select codes {snescmd, nmicmd, retvec, b1, b2, b3, pad_latch, snes_ajr}
  localparam logic [7:0] S_CMD = 8'h80;
  localparam logic [7:0] S_NMI = 8'h40;
  localparam logic [7:0] S_RET = 8'h20;
  localparam logic [7:0] S_B1  = 8'h10;
  localparam logic [7:0] S_B2  = 8'h08;
  localparam logic [7:0] S_B3  = 8'h04;
  localparam logic [14:0] REGION_HI = 15'h0015;
  localparam logic [23:0] NMI_LO = `NMI_VEC_LO;
  localparam logic [23:0] PARK = 24'h7E0000;

  logic clk;
  logic SNES_reset_strobe;
  logic [7:0] SNES_PA;
  logic [23:0] SNES_ADDR;
  cheat_pkg::snes_byte_t SNES_DATA;
  logic SNES_wr_strobe;
  logic SNES_rd_strobe;
  logic SNES_cycle_start;
  logic snescmd_enable;
  logic nmicmd_enable;
  logic return_vector_enable;
  logic branch1_enable;
  logic branch2_enable;
  logic branch3_enable;
  logic pad_latch;
  logic snes_ajr;
  cheat_pkg::pgm_slot_e pgm_idx;
  logic pgm_we;
  logic [31:0] pgm_in;
  cheat_pkg::snes_byte_t data_out;
  logic cheat_hit;
  logic snescmd_unlock;

  logic [31:0] seed = 32'h7096;
  int errors = 0;
  int checks = 0;
  int test_errors = 0;
  string test_name;
  logic [23:0] m_addr [`CHEAT_SLOTS];
  cheat_pkg::snes_byte_t m_data [`CHEAT_SLOTS];
  logic [5:0] m_mask;

  `include "cheat_model.svh"

  cheat_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (20000) @(posedge clk);
    $display("simulation stopped, the test sequence never finished");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // one bus clock; strobes last until the next call
  task automatic drive(input logic [23:0] addr, input cheat_pkg::snes_byte_t data,
      input logic [7:0] pa, input logic [2:0] strobes, input logic [7:0] sel);
    @(posedge clk);
    SNES_ADDR <= addr;
    SNES_DATA <= data;
    SNES_PA <= pa;
    {SNES_rd_strobe, SNES_wr_strobe, SNES_cycle_start} <= strobes;
    {snescmd_enable, nmicmd_enable, return_vector_enable, branch1_enable,
     branch2_enable, branch3_enable, pad_latch, snes_ajr} <= sel;
    pgm_we <= 1'b0;
    @(negedge clk);
  endtask

  task automatic host_write(input cheat_pkg::pgm_slot_e idx, input logic [31:0] value);
    @(posedge clk);
    pgm_idx <= idx;
    pgm_in <= value;
    pgm_we <= 1'b1;
    {SNES_rd_strobe, SNES_wr_strobe, SNES_cycle_start} <= NONE;
    @(negedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    SNES_reset_strobe <= 1'b1;
    {SNES_rd_strobe, SNES_wr_strobe, SNES_cycle_start} <= NONE;
    pgm_we <= 1'b0;
    repeat (2) @(posedge clk);
    SNES_reset_strobe <= 1'b0;
    @(negedge clk);
  endtask

  task automatic region_write(input logic [8:0] ofs, input cheat_pkg::snes_byte_t value);
    drive({REGION_HI, ofs}, value, 8'h00, WR, S_CMD);
  endtask

  // flaw 1 breaks the PA order, flaw 2 slips a read in before the last push
  task automatic push_seq(input logic [7:0] top, input int flaw);
    drive(PARK, 8'h00, 8'h00, RD, 8'h00);
    for (int i = 0; i < 4; i++) begin
      if (flaw == 2 && i == 3) begin
        drive(PARK, 8'h00, 8'h00, RD, 8'h00);
      end
      drive(24'h0001FF - 24'(i), 8'h00,
            (flaw == 1 && i == 2) ? top + 8'd7 : top - i[7:0], WR, 8'h00);
    end
    drive(`NMI_VEC_LO, 8'h00, 8'h00, RD, 8'h00);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string what, input cheat_pkg::snes_byte_t exp,
      input cheat_pkg::snes_byte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s: %s expected %02h actual %02h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic finish_test();
    $display("test %-10s %s (%0d errors)", test_name,
             (test_errors == 0) ? "passed" : "failed", test_errors);
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [23:0] addr;
    logic [15:0] pad;
    logic [5:0] set6;
    logic [7:0] pins;
    logic wram;
    cheat_pkg::pad_cmd_e cmd;
    cheat_pkg::snes_byte_t exp;
    int k;
    int pulses;

    SNES_reset_strobe <= 1'b1;
    SNES_PA <= 8'h00;
    SNES_ADDR <= 24'h000000;
    SNES_DATA <= 8'h00;
    {SNES_rd_strobe, SNES_wr_strobe, SNES_cycle_start} <= NONE;
    {snescmd_enable, nmicmd_enable, return_vector_enable, branch1_enable,
     branch2_enable, branch3_enable, pad_latch, snes_ajr} <= 8'h00;
    pgm_idx <= cheat_pkg::PGM_SLOT0;
    pgm_we <= 1'b0;
    pgm_in <= 32'h0;

    test_name = "reset_vec";
    apply_reset();
    for (int i = 0; i <= `RESET_FETCHES; i++) begin
      addr = (i % 2 == 0) ? `RST_VEC_LO : `RST_VEC_HI;
      drive(addr, 8'h00, 8'h00, RD | CS, 8'h00);
      check_bit("fetch hit", i < `RESET_FETCHES, cheat_hit);
      check_byte("fetch byte", vector_byte(addr), data_out);
      check_bit("unlock", i > 0, snescmd_unlock);
    end
    // unlocked by the reset path only, no nmi hook yet
    drive({REGION_HI, 9'h010}, 8'h00, 8'h00, NONE, S_NMI);
    check_bit("region hit without nmi", 1'b0, cheat_hit);
    finish_test();

    test_name = "patch";
    apply_reset();
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      r = lcg_next();
      m_addr[3'(i)] = (i == 4) ? m_addr[1] : {8'h40, 4'h0, r[27:16]};
      m_data[3'(i)] = r[7:0];
      host_write(cheat_pkg::pgm_slot_e'(3'(i)), {m_addr[3'(i)], m_data[3'(i)]});
    end
    // slots 1 and 4 share an address, both kept live
    m_mask = 6'(lcg_next() >> 26) | 6'h12;
    host_write(cheat_pkg::PGM_MASK, {26'd0, m_mask});
    host_write(cheat_pkg::PGM_FLAGS, 32'h0000_0001);
    for (int n = 0; n < 40; n++) begin
      r = lcg_next();
      k = int'(r[18:16]) % 6;
      addr = r[31] ? m_addr[3'(k)] : {8'h40, 4'h0, r[11:0]};
      drive(addr, 8'h00, 8'h00, RD, 8'h00);
      k = patch_slot(addr);
      if (k >= 0) begin
        exp = m_data[3'(k)];
      end else begin
        exp = vector_byte(addr);
      end
      check_bit("patch hit", k >= 0, cheat_hit);
      check_byte("patch byte", exp, data_out);
    end
    host_write(cheat_pkg::PGM_FLAGS, 32'h0000_0100);
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      drive(m_addr[3'(i)], 8'h00, 8'h00, RD, 8'h00);
      check_bit("hit with cheats off", 1'b0, cheat_hit);
    end
    finish_test();

    test_name = "nmi_hook";
    apply_reset();
    host_write(cheat_pkg::PGM_FLAGS, 32'h0000_0002);
    r = lcg_next();
    for (int f = 1; f <= 2; f++) begin
      push_seq(r[7:0], f);
      check_bit("broken entry hit", 1'b0, cheat_hit);
      drive(`NMI_VEC_LO, 8'h00, 8'h00, RD, 8'h00);
      check_bit("broken window hit", 1'b0, cheat_hit);
      check_bit("broken unlock", 1'b0, snescmd_unlock);
    end
    push_seq(r[7:0], 0);
    check_bit("entry hit", 1'b0, cheat_hit);
    for (int i = 0; i <= `VECTOR_READS; i++) begin
      addr = (i % 2 == 0) ? `NMI_VEC_LO : `NMI_VEC_HI;
      drive(addr, 8'h00, 8'h00, RD, 8'h00);
      check_bit("window hit", i < `VECTOR_READS, cheat_hit);
      check_byte("window byte", vector_byte(addr), data_out);
      check_bit("entry unlock", 1'b1, snescmd_unlock);
    end
    finish_test();

    test_name = "region";
    apply_reset();
    host_write(cheat_pkg::PGM_FLAGS, 32'h0000_0002);
    push_seq(8'(lcg_next() >> 24), 0);
    drive({REGION_HI, 9'h100}, 8'h00, 8'h00, RD, S_RET);
    check_byte("return vector", NMI_LO[7:0], data_out);
    check_bit("return vector hit", 1'b1, cheat_hit);
    for (int n = 0; n < 16; n++) begin
      r = lcg_next();
      k = int'(r[2:0]) % 7;
      pad = (k < 6) ? combo_value(k) : r[31:16];
      region_write(`OFS_PAD_LO, pad[7:0]);
      region_write(`OFS_PAD_HI, pad[15:8]);
      // nmi stays set; cheat, buttons and wram follow r
      set6 = {r[9], r[10], 2'b00, 1'b1, r[8]};
      host_write(cheat_pkg::PGM_FLAGS, {18'd0, ~set6, 2'b00, set6});
      pins = {6'd0, r[11], r[12]};
      cmd = pad_cmd_of(pad);
      wram = r[8] & r[9];
      drive({REGION_HI, 9'h010}, 8'h00, 8'h00, NONE, S_NMI | pins);
      check_byte("pad command", cmd, data_out);
      check_bit("region hit", 1'b1, cheat_hit);
      drive({REGION_HI, 9'h011}, 8'h00, 8'h00, NONE, S_B1 | pins);
      check_byte("branch1", branch1_of(r[10], r[12], r[11], wram, cmd), data_out);
      drive({REGION_HI, 9'h012}, 8'h00, 8'h00, NONE, S_B2 | pins);
      check_byte("branch2", branch2_of(cmd, wram), data_out);
    end
    drive({REGION_HI, 9'h013}, 8'h00, 8'h00, NONE, S_B3);
    check_byte("branch3", 8'h04, data_out);
    finish_test();

    test_name = "commands";
    apply_reset();
    r = lcg_next();
    m_addr[0] = {8'h41, r[15:0]};
    m_data[0] = r[23:16];
    host_write(cheat_pkg::PGM_SLOT0, {m_addr[0], m_data[0]});
    host_write(cheat_pkg::PGM_MASK, 32'h0000_0001);
    host_write(cheat_pkg::PGM_FLAGS, 32'h0000_0002);
    push_seq(r[31:24], 0);
    region_write(`OFS_CMD, cheat_pkg::CMD_CHEAT_ON);
    drive(m_addr[0], 8'h00, 8'h00, RD, 8'h00);
    check_bit("hit after cheat on", 1'b1, cheat_hit);
    check_byte("byte after cheat on", m_data[0], data_out);
    region_write(`OFS_CMD, cheat_pkg::CMD_CHEAT_OFF);
    drive(m_addr[0], 8'h00, 8'h00, RD, 8'h00);
    check_bit("hit after cheat off", 1'b0, cheat_hit);
    region_write(`OFS_CMD, cheat_pkg::CMD_HOOKS_OFF);
    push_seq(r[31:24], 0);
    drive(`NMI_VEC_LO, 8'h00, 8'h00, RD, 8'h00);
    check_bit("vector hit after hooks off", 1'b0, cheat_hit);
    check_bit("unlock before release", 1'b1, snescmd_unlock);
    region_write(`OFS_RELEASE, 8'h00);
    pulses = 0;
    while (snescmd_unlock === 1'b1 && pulses < 200) begin
      drive(PARK, 8'h00, 8'h00, CS, 8'h00);
      drive(PARK, 8'h00, 8'h00, NONE, 8'h00);
      pulses++;
    end
    if (pulses >= 200) begin
      errors++;
      test_errors++;
      $display("commands: snescmd_unlock never dropped after the release write");
    end else begin
      check_byte("release cycle_starts", 8'(`RELEASE_CYCLES + 1), 8'(pulses));
    end
    finish_test();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cheat_top.f
+incdir+common
+incdir+bench
common/cheat_pkg.sv
common/snes_bus_if.sv
common/hook_status_if.sv
design/patch_matcher/patch_matcher.sv
design/hook_tracker/hook_tracker.sv
design/cheat_ctrl/cheat_ctrl.sv
design/cheat_top.sv
bench/cheat_tb.sv

// File: common/cheat_consts.svh
`ifndef CHEAT_CONSTS_SVH
`define CHEAT_CONSTS_SVH

// rom patch slots
`define CHEAT_SLOTS 6

// native mode nmi and emulation mode reset vectors
`define NMI_VEC_LO 24'h00FFEA
`define NMI_VEC_HI 24'h00FFEB
`define RST_VEC_LO 24'h00FFFC
`define RST_VEC_HI 24'h00FFFD

// replacement vector bytes, pointing into snescmd
`define HOOK_LO_BYTE 8'h10
`define RST_LO_BYTE  8'h7D
`define FILL_BYTE    8'h2A

// offsets inside the snescmd region
`define OFS_CMD     9'h000
`define OFS_PAD_LO  9'h1F0
`define OFS_PAD_HI  9'h1F1
`define OFS_RELEASE 9'h1FD

// hold counts
`define RELEASE_CYCLES 72
`define RESET_FETCHES  3
`define VECTOR_READS   2

`endif

// File: common/cheat_pkg.sv
`default_nettype none

package cheat_pkg;

  typedef logic [7:0] snes_byte_t;

  // commands written to offset 0 of the snescmd region
  typedef enum logic [7:0] {
    CMD_CHEAT_ON  = 8'h82,
    CMD_CHEAT_OFF = 8'h83,
    CMD_HOOKS_OFF = 8'h84
  } region_cmd_e;

  // commands decoded from joypad combos
  typedef enum logic [7:0] {
    PAD_NONE      = 8'h00,
    PAD_MENU      = 8'h80,
    PAD_STOP      = 8'h81,
    PAD_CHEAT_ON  = 8'h82,
    PAD_CHEAT_OFF = 8'h83,
    PAD_HOOKS_OFF = 8'h84,
    PAD_HOLDOFF   = 8'h85
  } pad_cmd_e;

  // host programming index
  typedef enum logic [2:0] {
    PGM_SLOT0 = 3'd0,
    PGM_SLOT1 = 3'd1,
    PGM_SLOT2 = 3'd2,
    PGM_SLOT3 = 3'd3,
    PGM_SLOT4 = 3'd4,
    PGM_SLOT5 = 3'd5,
    PGM_MASK  = 3'd6,
    PGM_FLAGS = 3'd7
  } pgm_slot_e;

endpackage

`default_nettype wire

// File: common/hook_status_if.sv
`timescale 1ns/1ps
`default_nettype none

// hook state shared between tracker and controller
interface hook_status_if;
  logic                  snescmd_unlock;
  logic                  vector_window;
  logic                  reset_window;
  cheat_pkg::snes_byte_t return_vector;
  logic                  hook_live;
  logic                  nmi_hook_en;
  // unlocked write strobe into the region
  logic                  region_wr;

  modport tracker (
    output snescmd_unlock, vector_window, reset_window, return_vector, hook_live,
    input  nmi_hook_en, region_wr
  );
  modport ctrl (
    input  snescmd_unlock, vector_window, reset_window, return_vector, hook_live,
    output nmi_hook_en, region_wr
  );
endinterface

`default_nettype wire

// File: common/snes_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// console bus as sampled by the cart
interface snes_bus_if;
  logic [23:0]           addr;
  logic [7:0]            pa;
  cheat_pkg::snes_byte_t data;
  logic                  wr_strobe;
  logic                  rd_strobe;
  logic                  cycle_start;

  modport monitor (input addr, pa, data, wr_strobe, rd_strobe, cycle_start);
endinterface

`default_nettype wire

// File: design/cheat_ctrl/cheat_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cheat_consts.svh"

module cheat_ctrl (
  input  logic                  clk,
  input  logic                  SNES_reset_strobe,
  snes_bus_if.monitor           bus,
  hook_status_if.ctrl           hook,
  input  cheat_pkg::pgm_slot_e  pgm_idx,
  input  logic                  pgm_we,
  input  logic [31:0]           pgm_in,
  input  logic                  patch_match,
  input  cheat_pkg::snes_byte_t patch_byte,
  input  logic                  snescmd_enable,
  input  logic                  nmicmd_enable,
  input  logic                  return_vector_enable,
  input  logic                  branch1_enable,
  input  logic                  branch2_enable,
  input  logic                  branch3_enable,
  input  logic                  pad_latch,
  input  logic                  snes_ajr,
  output cheat_pkg::snes_byte_t data_out,
  output logic                  cheat_hit
);

  // flag positions; bit 3 is the hold-off flag, kept for the host only
  localparam int F_CHEAT   = 0;
  localparam int F_NMI     = 1;
  localparam int F_IRQ     = 2;
  localparam int F_BUTTONS = 4;
  localparam int F_WRAM    = 5;

  logic [5:0]            flags;
  logic [15:0]           pad_data;
  cheat_pkg::pad_cmd_e   pad_cmd;
  cheat_pkg::snes_byte_t exit_ofs;
  cheat_pkg::snes_byte_t branch1_ofs;
  cheat_pkg::snes_byte_t branch2_ofs;
  logic                  region_wr;
  logic                  pad_wr;
  logic                  wram;
  logic                  region_sel;
  logic                  nmi_addr;
  logic                  rst_addr;

  assign pad_wr     = snescmd_enable && bus.wr_strobe;
  assign region_wr  = pad_wr && hook.snescmd_unlock;
  assign wram       = flags[F_CHEAT] && flags[F_WRAM];
  assign region_sel = nmicmd_enable || return_vector_enable || branch1_enable
                      || branch2_enable || branch3_enable;
  assign nmi_addr   = (bus.addr == `NMI_VEC_LO) || (bus.addr == `NMI_VEC_HI);
  assign rst_addr   = (bus.addr == `RST_VEC_LO) || (bus.addr == `RST_VEC_HI);

  assign hook.region_wr   = region_wr;
  assign hook.nmi_hook_en = flags[F_NMI];

  ////////////////////////////////////////////////////////////////////////////
  // global flags
  ////////////////////////////////////////////////////////////////////////////

  // slot 7: clear mask in 13:8, set mask in 5:0
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      flags <= '0;
    end else if (region_wr && bus.addr[8:0] == `OFS_CMD) begin
      case (cheat_pkg::region_cmd_e'(bus.data))
        cheat_pkg::CMD_CHEAT_ON:  flags[F_CHEAT] <= 1'b1;
        cheat_pkg::CMD_CHEAT_OFF: flags[F_CHEAT] <= 1'b0;
        cheat_pkg::CMD_HOOKS_OFF: flags[F_IRQ:F_NMI] <= 2'b00;
        default:                  flags <= flags;
      endcase
    end else if (pgm_we && pgm_idx == cheat_pkg::PGM_FLAGS) begin
      flags <= (flags & ~pgm_in[13:8]) | pgm_in[5:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // joypad combos
  ////////////////////////////////////////////////////////////////////////////

  // hook code copies the pad registers here every frame
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      pad_data <= '0;
    end else if (pad_wr) begin
      if (bus.addr[8:0] == `OFS_PAD_LO) begin
        pad_data[7:0] <= bus.data;
      end else if (bus.addr[8:0] == `OFS_PAD_HI) begin
        pad_data[15:8] <= bus.data;
      end
    end
  end

  // all combos hold L+R
  always_comb begin
    case (pad_data)
      16'h3030: pad_cmd = cheat_pkg::PAD_MENU;      // start+select
      16'h2070: pad_cmd = cheat_pkg::PAD_STOP;      // select+x
      16'h10B0: pad_cmd = cheat_pkg::PAD_CHEAT_ON;  // start+a
      16'h9030: pad_cmd = cheat_pkg::PAD_CHEAT_OFF; // start+b
      16'h5030: pad_cmd = cheat_pkg::PAD_HOOKS_OFF; // start+y
      16'h1070: pad_cmd = cheat_pkg::PAD_HOLDOFF;   // start+x
      default:  pad_cmd = cheat_pkg::PAD_NONE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // branch offsets into the hook code
  ////////////////////////////////////////////////////////////////////////////

  // nmi_patches when wram patching is live, nmi_exit otherwise
  assign exit_ofs = wram ? 8'h3A : 8'h43;

  always_comb begin
    if (!flags[F_BUTTONS]) begin
      branch1_ofs = exit_ofs;
    end else if (snes_ajr) begin
      // nmi_echocmd when a combo is held
      branch1_ofs = (pad_cmd != cheat_pkg::PAD_NONE) ? 8'h30 : exit_ofs;
    end else if (pad_latch) begin
      branch1_ofs = exit_ofs;
    end else begin
      // no auto read yet, go poll the pad
      branch1_ofs = 8'h00;
    end
  end

  always_comb begin
    if (pad_cmd == cheat_pkg::PAD_STOP) begin
      branch2_ofs = 8'h14;
    end else begin
      branch2_ofs = wram ? 8'h00 : 8'h09;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data and hit
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (patch_match) begin
      data_out = patch_byte;
    end else if (bus.addr == `NMI_VEC_LO) begin
      data_out = `HOOK_LO_BYTE;
    end else if (bus.addr == `RST_VEC_LO) begin
      data_out = `RST_LO_BYTE;
    end else if (nmicmd_enable) begin
      data_out = pad_cmd;
    end else if (return_vector_enable) begin
      data_out = hook.return_vector;
    end else if (branch1_enable) begin
      data_out = branch1_ofs;
    end else if (branch2_enable) begin
      data_out = branch2_ofs;
    end else if (branch3_enable) begin
      data_out = 8'h04;
    end else begin
      data_out = `FILL_BYTE;
    end
  end

  assign cheat_hit = (flags[F_CHEAT] && patch_match)
                     || (hook.reset_window && rst_addr)
                     || (flags[F_NMI] && hook.vector_window && nmi_addr)
                     || (hook.hook_live && region_sel);

endmodule

`default_nettype wire

// File: design/cheat_top.sv
`timescale 1ns/1ps
`default_nettype none

module cheat_top (
  input  logic                  clk,
  input  logic                  SNES_reset_strobe,
  input  logic [7:0]            SNES_PA,
  input  logic [23:0]           SNES_ADDR,
  input  cheat_pkg::snes_byte_t SNES_DATA,
  input  logic                  SNES_wr_strobe,
  input  logic                  SNES_rd_strobe,
  input  logic                  SNES_cycle_start,
  input  logic                  snescmd_enable,
  input  logic                  nmicmd_enable,
  input  logic                  return_vector_enable,
  input  logic                  branch1_enable,
  input  logic                  branch2_enable,
  input  logic                  branch3_enable,
  input  logic                  pad_latch,
  input  logic                  snes_ajr,
  input  cheat_pkg::pgm_slot_e  pgm_idx,
  input  logic                  pgm_we,
  input  logic [31:0]           pgm_in,
  output cheat_pkg::snes_byte_t data_out,
  output logic                  cheat_hit,
  output logic                  snescmd_unlock
);

  logic                  patch_match;
  cheat_pkg::snes_byte_t patch_byte;

  snes_bus_if    bus_if ();
  hook_status_if hook_if ();

  assign bus_if.addr        = SNES_ADDR;
  assign bus_if.pa          = SNES_PA;
  assign bus_if.data        = SNES_DATA;
  assign bus_if.wr_strobe   = SNES_wr_strobe;
  assign bus_if.rd_strobe   = SNES_rd_strobe;
  assign bus_if.cycle_start = SNES_cycle_start;

  assign snescmd_unlock = hook_if.snescmd_unlock;

  patch_matcher matcher0 (
    .clk(clk), .SNES_reset_strobe(SNES_reset_strobe), .bus(bus_if),
    .pgm_idx(pgm_idx), .pgm_we(pgm_we), .pgm_in(pgm_in),
    .patch_match(patch_match), .patch_byte(patch_byte)
  );

  hook_tracker tracker0 (
    .clk(clk), .SNES_reset_strobe(SNES_reset_strobe), .bus(bus_if), .hook(hook_if)
  );

  cheat_ctrl ctrl0 (
    .clk(clk), .SNES_reset_strobe(SNES_reset_strobe), .bus(bus_if), .hook(hook_if),
    .pgm_idx(pgm_idx), .pgm_we(pgm_we), .pgm_in(pgm_in),
    .patch_match(patch_match), .patch_byte(patch_byte),
    .snescmd_enable(snescmd_enable), .nmicmd_enable(nmicmd_enable),
    .return_vector_enable(return_vector_enable),
    .branch1_enable(branch1_enable), .branch2_enable(branch2_enable),
    .branch3_enable(branch3_enable), .pad_latch(pad_latch), .snes_ajr(snes_ajr),
    .data_out(data_out), .cheat_hit(cheat_hit)
  );

endmodule

`default_nettype wire

// File: design/hook_tracker/hook_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cheat_consts.svh"

module hook_tracker (
  input  logic           clk,
  input  logic           SNES_reset_strobe,
  snes_bus_if.monitor    bus,
  hook_status_if.tracker hook
);

  localparam int VEC_W = $clog2(`VECTOR_READS + 1);
  localparam int RST_W = $clog2(`RESET_FETCHES + 1);
  localparam int REL_W = $clog2(`RELEASE_CYCLES + 1);

  logic [2:0]            push_cnt;
  logic [7:0]            next_pa;
  logic [VEC_W-1:0]      vec_cnt;
  logic [RST_W-1:0]      rst_cnt;
  logic [REL_W-1:0]      rel_cnt;
  logic                  rel_armed;
  logic                  unlock_r;
  logic                  nmi_taken;
  cheat_pkg::snes_byte_t ret_vec;
  logic                  rst_addr;
  logic                  nmi_entry;
  logic                  rst_entry;
  logic                  rel_strobe;

  assign rst_addr   = (bus.addr == `RST_VEC_LO) || (bus.addr == `RST_VEC_HI);
  // interrupt entry: vector fetch right after a complete push
  assign nmi_entry  = bus.rd_strobe && hook.nmi_hook_en && (push_cnt == 3'd4)
                      && (bus.addr == `NMI_VEC_LO);
  assign rst_entry  = bus.rd_strobe && (rst_cnt != '0) && (bus.addr == `RST_VEC_LO);
  assign rel_strobe = hook.region_wr && (bus.addr[8:0] == `OFS_RELEASE);

  ////////////////////////////////////////////////////////////////////////////
  // stack push detection
  ////////////////////////////////////////////////////////////////////////////

  // the cpu pushes PB, PCH, PCL and P to descending stack addresses;
  // the B bus mirror of those writes keeps DMA from faking the pattern
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      push_cnt <= '0;
    end else if (bus.wr_strobe) begin
      if (push_cnt == '0) begin
        push_cnt <= 3'd1;
      end else if (bus.pa == next_pa) begin
        push_cnt <= push_cnt + 3'd1;
      end else begin
        push_cnt <= '0;
      end
    end else if (bus.rd_strobe) begin
      push_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.wr_strobe) begin
      if (push_cnt == '0) begin
        next_pa <= bus.pa - 8'd1;
      end else if (bus.pa == next_pa) begin
        next_pa <= next_pa - 8'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // vector windows
  ////////////////////////////////////////////////////////////////////////////

  // patched nmi vector visible for the two following reads only
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      vec_cnt <= '0;
    end else if (nmi_entry) begin
      vec_cnt <= VEC_W'(`VECTOR_READS);
    end else if (bus.rd_strobe && vec_cnt != '0) begin
      vec_cnt <= vec_cnt - VEC_W'(1);
    end
  end

  // reset vector patched for the first fetches after reset,
  // some adapters read it more than once
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      rst_cnt <= RST_W'(`RESET_FETCHES);
    end else if (bus.cycle_start && rst_addr && rst_cnt != '0) begin
      rst_cnt <= rst_cnt - RST_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // snescmd unlock and release
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      unlock_r  <= 1'b0;
      nmi_taken <= 1'b0;
      rel_armed <= 1'b0;
      rel_cnt   <= '0;
      ret_vec   <= '0;
    end else begin
      // leave the hook code time to jump out of the region
      if (bus.cycle_start && rel_armed) begin
        if (rel_cnt != '0) begin
          rel_cnt <= rel_cnt - REL_W'(1);
        end else begin
          unlock_r  <= 1'b0;
          nmi_taken <= 1'b0;
          rel_armed <= 1'b0;
        end
      end
      if (rel_strobe) begin
        rel_cnt   <= REL_W'(`RELEASE_CYCLES);
        rel_armed <= 1'b1;
      end
      // remember the vector so the exit path can resume there
      if (nmi_entry) begin
        ret_vec   <= bus.addr[7:0];
        unlock_r  <= 1'b1;
        nmi_taken <= 1'b1;
      end
      if (rst_entry) begin
        unlock_r <= 1'b1;
      end
    end
  end

  assign hook.snescmd_unlock = unlock_r;
  assign hook.vector_window  = (vec_cnt != '0);
  assign hook.reset_window   = (rst_cnt != '0);
  assign hook.return_vector  = ret_vec;
  // region bytes belong to the nmi hook, not to the reset path
  assign hook.hook_live      = unlock_r && nmi_taken;

endmodule

`default_nettype wire

// File: design/patch_matcher/patch_matcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "cheat_consts.svh"

module patch_matcher (
  input  logic                  clk,
  input  logic                  SNES_reset_strobe,
  snes_bus_if.monitor           bus,
  input  cheat_pkg::pgm_slot_e  pgm_idx,
  input  logic                  pgm_we,
  input  logic [31:0]           pgm_in,
  output logic                  patch_match,
  output cheat_pkg::snes_byte_t patch_byte
);

  logic [23:0]             slot_addr [`CHEAT_SLOTS];
  cheat_pkg::snes_byte_t   slot_data [`CHEAT_SLOTS];
  logic [`CHEAT_SLOTS-1:0] enable_mask;
  logic [`CHEAT_SLOTS-1:0] match_bits;

  ////////////////////////////////////////////////////////////////////////////
  // host programming
  ////////////////////////////////////////////////////////////////////////////

  // slot layout: address in 31:8, replacement byte in 7:0
  always_ff @(posedge clk) begin
    if (pgm_we) begin
      for (int i = 0; i < `CHEAT_SLOTS; i++) begin
        if (int'(pgm_idx) == i) begin
          slot_addr[i] <= pgm_in[31:8];
          slot_data[i] <= pgm_in[7:0];
        end
      end
    end
  end

  // per slot enable, one bit each
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      enable_mask <= '0;
    end else if (pgm_we && pgm_idx == cheat_pkg::PGM_MASK) begin
      enable_mask <= pgm_in[`CHEAT_SLOTS-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // address compare
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `CHEAT_SLOTS; i++) begin
      match_bits[i] = enable_mask[i] && (bus.addr == slot_addr[i]);
    end
  end

  assign patch_match = |match_bits;

  // walk down so slot 0 wins when several slots share an address
  always_comb begin
    patch_byte = `FILL_BYTE;
    for (int i = `CHEAT_SLOTS - 1; i >= 0; i--) begin
      if (match_bits[i]) begin
        patch_byte = slot_data[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the cheat unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f cheat_top.f --top-module cheat_tb --Mdir "$OBJ" -o cheat_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"$OBJ/cheat_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
